// ==== verilog/clint_defines.svh ====
`ifndef CLINT_DEFINES_SVH
`define CLINT_DEFINES_SVH

// data path of the register port, one full 64-bit register per beat
`define CLINT_DATA_W 64
`define CLINT_STRB_W 8

// offset inside the CLINT window, base already stripped by the interconnect
`define CLINT_ADDR_W 16

// register map
`define CLINT_MTIMECMP_OFS 16'h4000
`define CLINT_MTIME_OFS    16'hBFF8

`endif

// ==== verilog/clint_pkg.sv ====
`include "clint_defines.svh"

package clint_pkg;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_t;

    // strobed lanes take the new data, the others keep the old value
    function automatic logic [`CLINT_DATA_W-1:0] merge_bytes(
        input logic [`CLINT_DATA_W-1:0] old_val,
        input logic [`CLINT_DATA_W-1:0] wdata,
        input logic [`CLINT_STRB_W-1:0] wstrb
    );
        logic [`CLINT_DATA_W-1:0] merged;
        int                       i;
        merged = old_val;
        for (i = 0; i < `CLINT_STRB_W; i++)
        begin
            if (wstrb[i])
                merged[i*8 +: 8] = wdata[i*8 +: 8];
        end
        return merged;
    endfunction

endpackage

// ==== verilog/clint_reg_if.sv ====
`timescale 1ns/1ps
`include "clint_defines.svh"

interface clint_reg_if;

    // write enables, already decoded by the bus slave
    logic                     mtime_we;
    logic                     mtimecmp_we;

    // shared write payload
    logic [`CLINT_DATA_W-1:0] wdata;
    logic [`CLINT_STRB_W-1:0] wstrb;

    // current register contents
    logic [`CLINT_DATA_W-1:0] mtime;
    logic [`CLINT_DATA_W-1:0] mtimecmp;

    modport bus (
        output mtime_we, mtimecmp_we, wdata, wstrb,
        input  mtime, mtimecmp
    );

    modport timer (
        input  mtime_we, wdata, wstrb,
        output mtime
    );

    // the compare block also watches the running time
    modport cmp (
        input  mtimecmp_we, wdata, wstrb, mtime,
        output mtimecmp
    );

endinterface

// ==== verilog/clint_axi_slave.sv ====
`timescale 1ns/1ps
`include "clint_defines.svh"

module clint_axi_slave (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`CLINT_ADDR_W-1:0] awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [`CLINT_DATA_W-1:0] wdata,
    input  logic [`CLINT_STRB_W-1:0] wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    output clint_pkg::axi_resp_t     bresp,
    output logic                     bvalid,
    input  logic                     bready,
    input  logic [`CLINT_ADDR_W-1:0] araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output logic [`CLINT_DATA_W-1:0] rdata,
    output clint_pkg::axi_resp_t     rresp,
    output logic                     rvalid,
    input  logic                     rready,
    clint_reg_if.bus                 regs
);
    import clint_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WDATA,
        BRESP,
        RRESP
    } state_t;

    state_t                   state;
    state_t                   state_nxt;
    logic [`CLINT_ADDR_W-1:0] awaddr_q;
    logic                     aw_fire;
    logic                     w_fire;
    logic                     b_fire;
    logic                     ar_fire;
    logic                     r_fire;
    logic                     wr_hit_mtime;
    logic                     wr_hit_cmp;

    // handshake outputs come straight from the state
    assign awready = (state == IDLE);
    // write wins when both address channels are valid in the same cycle
    assign arready = (state == IDLE) && !awvalid;
    assign wready  = (state == WDATA);
    assign bvalid  = (state == BRESP);
    assign rvalid  = (state == RRESP);

    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign b_fire  = bvalid && bready;
    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;

    always_comb
    begin
        state_nxt = state;
        case (state)
            IDLE:
            begin
                if (aw_fire)
                    state_nxt = WDATA;
                else if (ar_fire)
                    state_nxt = RRESP;
            end
            WDATA:
            begin
                if (w_fire)
                    state_nxt = BRESP;
            end
            BRESP:
            begin
                if (b_fire)
                    state_nxt = IDLE;
            end
            RRESP:
            begin
                if (r_fire)
                    state_nxt = IDLE;
            end
            default:
                state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state <= IDLE;
        else
            state <= state_nxt;
    end

    always_ff @(posedge clk)
    begin
        if (aw_fire)
            awaddr_q <= awaddr;
    end

    // write decode against the latched write address
    assign wr_hit_mtime = (awaddr_q == `CLINT_MTIME_OFS);
    assign wr_hit_cmp   = (awaddr_q == `CLINT_MTIMECMP_OFS);

    // at most one enable, and only on the w transfer edge
    assign regs.mtime_we    = w_fire && wr_hit_mtime;
    assign regs.mtimecmp_we = w_fire && wr_hit_cmp;
    assign regs.wdata       = wdata;
    assign regs.wstrb       = wstrb;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            bresp <= RESP_OKAY;
        else if (w_fire)
            bresp <= (wr_hit_mtime || wr_hit_cmp) ? RESP_OKAY : RESP_SLVERR;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            rresp <= RESP_OKAY;
        else if (ar_fire)
            rresp <= (araddr == `CLINT_MTIME_OFS || araddr == `CLINT_MTIMECMP_OFS) ?
                     RESP_OKAY : RESP_SLVERR;
    end

    // read decode uses the read address and is held until the r transfer
    always_ff @(posedge clk)
    begin
        if (ar_fire)
        begin
            case (araddr)
                // count as it stands after the ar edge, no write lands on this edge
                `CLINT_MTIME_OFS:    rdata <= regs.mtime + 1'b1;
                `CLINT_MTIMECMP_OFS: rdata <= regs.mtimecmp;
                default:             rdata <= '0;
            endcase
        end
    end

endmodule

// ==== verilog/clint_mtime.sv ====
`timescale 1ns/1ps
`include "clint_defines.svh"

module clint_mtime (
    input  logic       clk,
    input  logic       rst_n,
    clint_reg_if.timer regs
);
    import clint_pkg::*;

    logic [`CLINT_DATA_W-1:0] count_q;

    // free-running, a write replaces the increment on its edge
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            count_q <= '0;
        end
        else if (regs.mtime_we)
        begin
            count_q <= merge_bytes(count_q, regs.wdata, regs.wstrb);
        end
        else
        begin
            count_q <= count_q + 1'b1;
        end
    end

    assign regs.mtime = count_q;

endmodule

// ==== verilog/clint_mtimecmp.sv ====
`timescale 1ns/1ps
`include "clint_defines.svh"

module clint_mtimecmp (
    input  logic     clk,
    input  logic     rst_n,
    output logic     timer_irq,
    clint_reg_if.cmp regs
);
    import clint_pkg::*;

    logic [`CLINT_DATA_W-1:0] cmp_val_q;
    logic                     cmp_q;
    logic                     cmp_prev_q;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            cmp_val_q <= '0;
        else if (regs.mtimecmp_we)
            cmp_val_q <= merge_bytes(cmp_val_q, regs.wdata, regs.wstrb);
    end

    assign regs.mtimecmp = cmp_val_q;

    // unsigned compare, registered once, then edge-detected
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cmp_q      <= 1'b0;
            cmp_prev_q <= 1'b0;
        end
        else
        begin
            cmp_q      <= (regs.mtime >= cmp_val_q);
            cmp_prev_q <= cmp_q;
        end
    end

    // one pulse per crossing, the level stays high while mtime is past the compare
    assign timer_irq = cmp_q && !cmp_prev_q;

endmodule

// ==== verilog/clint_top.sv ====
`timescale 1ns/1ps
`include "clint_defines.svh"

module clint_top (
    input  logic                     clk,
    input  logic                     rst_n,

    input  logic [`CLINT_ADDR_W-1:0] s_axi_awaddr,
    input  logic                     s_axi_awvalid,
    output logic                     s_axi_awready,

    input  logic [`CLINT_DATA_W-1:0] s_axi_wdata,
    input  logic [`CLINT_STRB_W-1:0] s_axi_wstrb,
    input  logic                     s_axi_wvalid,
    output logic                     s_axi_wready,

    output clint_pkg::axi_resp_t     s_axi_bresp,
    output logic                     s_axi_bvalid,
    input  logic                     s_axi_bready,

    input  logic [`CLINT_ADDR_W-1:0] s_axi_araddr,
    input  logic                     s_axi_arvalid,
    output logic                     s_axi_arready,

    output logic [`CLINT_DATA_W-1:0] s_axi_rdata,
    output clint_pkg::axi_resp_t     s_axi_rresp,
    output logic                     s_axi_rvalid,
    input  logic                     s_axi_rready,

    output logic                     timer_irq
);
    import clint_pkg::*;

    // decoded register access between the slave and both registers
    clint_reg_if regs_if ();

    clint_axi_slave axi_slave_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .awaddr  (s_axi_awaddr),
        .awvalid (s_axi_awvalid),
        .awready (s_axi_awready),
        .wdata   (s_axi_wdata),
        .wstrb   (s_axi_wstrb),
        .wvalid  (s_axi_wvalid),
        .wready  (s_axi_wready),
        .bresp   (s_axi_bresp),
        .bvalid  (s_axi_bvalid),
        .bready  (s_axi_bready),
        .araddr  (s_axi_araddr),
        .arvalid (s_axi_arvalid),
        .arready (s_axi_arready),
        .rdata   (s_axi_rdata),
        .rresp   (s_axi_rresp),
        .rvalid  (s_axi_rvalid),
        .rready  (s_axi_rready),
        .regs    (regs_if.bus)
    );

    clint_mtime mtime_i (
        .clk   (clk),
        .rst_n (rst_n),
        .regs  (regs_if.timer)
    );

    clint_mtimecmp mtimecmp_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .timer_irq (timer_irq),
        .regs      (regs_if.cmp)
    );

endmodule

// ==== tests/clint_asserts.sv ====
`timescale 1ns/1ps

module clint_asserts (
    input logic clk,
    input logic rst_n,
    input logic bvalid,
    input logic bready,
    input logic rvalid,
    input logic rready,
    input logic wready,
    input logic timer_irq
);

    // read by the testbench top, nonzero once any property below has failed
    int fail_cnt = 0;

    // a write response is held until the master takes it
    bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid)
    else
    begin
        $error("bvalid dropped before bready");
        fail_cnt++;
    end

    rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid)
    else
    begin
        $error("rvalid dropped before rready");
        fail_cnt++;
    end

    // one event per crossing
    irq_single: assert property (@(posedge clk) disable iff (!rst_n)
        timer_irq |=> !timer_irq)
    else
    begin
        $error("timer_irq high for two cycles in a row");
        fail_cnt++;
    end

    // only one transaction is in flight
    wready_alone: assert property (@(posedge clk) disable iff (!rst_n)
        !(wready && (bvalid || rvalid)))
    else
    begin
        $error("wready high together with a response valid");
        fail_cnt++;
    end

    resp_idle_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !bvalid && !rvalid)
    else
    begin
        $error("response valid high in the first cycle after reset");
        fail_cnt++;
    end

endmodule

bind clint_top clint_asserts asserts_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .bvalid    (s_axi_bvalid),
    .bready    (s_axi_bready),
    .rvalid    (s_axi_rvalid),
    .rready    (s_axi_rready),
    .wready    (s_axi_wready),
    .timer_irq (timer_irq)
);

// ==== tests/clint_tb.sv ====
`timescale 1ns/1ps
`include "clint_defines.svh"

module clint_tb;
    import clint_pkg::*;

    localparam int CLK_PERIOD     = 100;
    localparam int TXN_BUDGET     = 40;
    localparam int CYCLES_PER_TXN = 50;
    localparam logic [`CLINT_ADDR_W-1:0] UNMAPPED_OFS = 16'h0100;

    logic                     clk = 1'b0;
    logic                     rst_n;
    logic [`CLINT_ADDR_W-1:0] awaddr;
    logic                     awvalid;
    logic                     awready;
    logic [`CLINT_DATA_W-1:0] wdata;
    logic [`CLINT_STRB_W-1:0] wstrb;
    logic                     wvalid;
    logic                     wready;
    axi_resp_t                bresp;
    logic                     bvalid;
    logic                     bready;
    logic [`CLINT_ADDR_W-1:0] araddr;
    logic                     arvalid;
    logic                     arready;
    logic [`CLINT_DATA_W-1:0] rdata;
    axi_resp_t                rresp;
    logic                     rvalid;
    logic                     rready;
    logic                     timer_irq;

    int          edge_cnt = 0;
    int          irq_edges[$];
    logic [31:0] lcg_state = 32'd46626;

    clint_top dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .s_axi_awaddr  (awaddr),
        .s_axi_awvalid (awvalid),
        .s_axi_awready (awready),
        .s_axi_wdata   (wdata),
        .s_axi_wstrb   (wstrb),
        .s_axi_wvalid  (wvalid),
        .s_axi_wready  (wready),
        .s_axi_bresp   (bresp),
        .s_axi_bvalid  (bvalid),
        .s_axi_bready  (bready),
        .s_axi_araddr  (araddr),
        .s_axi_arvalid (arvalid),
        .s_axi_arready (arready),
        .s_axi_rdata   (rdata),
        .s_axi_rresp   (rresp),
        .s_axi_rvalid  (rvalid),
        .s_axi_rready  (rready),
        .timer_irq     (timer_irq)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // an edge is known by the count sampled at it
    always @(posedge clk)
        edge_cnt <= edge_cnt + 1;

    always @(posedge clk)
    begin
        if (timer_irq === 1'b1)
            irq_edges.push_back(edge_cnt);
        if (dut_i.asserts_i.fail_cnt != 0)
        begin
            $display("a bound protocol assertion failed");
            $display("TESTS FAILED");
            $fatal(1);
        end
    end

    initial
    begin
        #(TXN_BUDGET * CYCLES_PER_TXN * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("TESTS FAILED");
        $fatal(1);
    end

    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function logic [63:0] rand64();
        logic [31:0] hi;
        hi = lcg_next();
        return {hi, lcg_next()};
    endfunction

    // expected register after a strobed write, built from a byte mask
    function automatic logic [63:0] apply_strobes(
        input logic [63:0] old_val,
        input logic [63:0] new_val,
        input logic [7:0]  strb
    );
        logic [63:0] mask;
        mask = '0;
        for (int b = 0; b < 8; b++)
            mask[b*8 +: 8] = {8{strb[b]}};
        return (old_val & ~mask) | (new_val & mask);
    endfunction

    task automatic check(input logic cond, input string msg);
        assert (cond === 1'b1)
        else
        begin
            $display("CHECK FAILED at %0t ns: %s", $time, msg);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic wait_until_edge(input int target);
        while (edge_cnt < target)
            @(posedge clk);
    endtask

    // exactly one pulse in [lo, hi], sampled at edge expect_edge
    task automatic check_pulse_window(input int lo, input int hi, input int expect_edge);
        int hits;
        int seen;
        hits = 0;
        seen = -1;
        foreach (irq_edges[i])
        begin
            if (irq_edges[i] >= lo && irq_edges[i] <= hi)
            begin
                hits++;
                seen = irq_edges[i];
            end
        end
        check(hits == 1, $sformatf("%0d timer_irq pulses in edges %0d..%0d", hits, lo, hi));
        check(seen == expect_edge,
              $sformatf("timer_irq seen at edge %0d, expected %0d", seen, expect_edge));
    endtask

    task automatic axi_write(
        input  logic [`CLINT_ADDR_W-1:0] addr,
        input  logic [63:0]              data,
        input  logic [7:0]               strb,
        output axi_resp_t                resp,
        output int                       w_edge
    );
        @(posedge clk);
        awaddr  <= addr;
        awvalid <= 1'b1;
        @(posedge clk);
        while (awready !== 1'b1)
            @(posedge clk);
        awvalid <= 1'b0;
        wdata   <= data;
        wstrb   <= strb;
        wvalid  <= 1'b1;
        @(posedge clk);
        while (wready !== 1'b1)
            @(posedge clk);
        w_edge = edge_cnt;
        wvalid <= 1'b0;
        bready <= 1'b1;
        @(posedge clk);
        while (bvalid !== 1'b1)
            @(posedge clk);
        resp = bresp;
        bready <= 1'b0;
    endtask

    // holds rready low for hold cycles once rvalid is up
    task automatic axi_read(
        input  logic [`CLINT_ADDR_W-1:0] addr,
        input  int                       hold,
        output logic [63:0]              data,
        output axi_resp_t                resp,
        output int                       ar_edge
    );
        logic [63:0] held;
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        @(posedge clk);
        while (arready !== 1'b1)
            @(posedge clk);
        ar_edge = edge_cnt;
        arvalid <= 1'b0;
        @(posedge clk);
        while (rvalid !== 1'b1)
            @(posedge clk);
        held = rdata;
        repeat (hold)
        begin
            @(posedge clk);
            check(rvalid, "rvalid dropped while rready was low");
            check(rdata === held, $sformatf("rdata moved from %h to %h", held, rdata));
        end
        rready <= 1'b1;
        @(posedge clk);
        data = rdata;
        resp = rresp;
        rready <= 1'b0;
    endtask

    initial
    begin
        logic [63:0] cmp_model;
        logic [63:0] mtime_val;
        logic [63:0] data;
        logic [63:0] got;
        logic [63:0] expected;
        logic [7:0]  strb;
        axi_resp_t   resp;
        int          rst_edge;
        int          w_edge;
        int          r_edge;
        int          c_edge;

        rst_n   <= 1'b0;
        awaddr  <= '0;
        awvalid <= 1'b0;
        wdata   <= '0;
        wstrb   <= '0;
        wvalid  <= 1'b0;
        bready  <= 1'b0;
        araddr  <= '0;
        arvalid <= 1'b0;
        rready  <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n    <= 1'b1;
        rst_edge = edge_cnt;

        // reset state, then the pulse from both registers being zero
        @(posedge clk);
        check(awready === 1'b1 && arready === 1'b1, "address channels not ready after reset");
        check(bvalid === 1'b0 && rvalid === 1'b0 && wready === 1'b0,
              "response or wready high after reset");
        wait_until_edge(rst_edge + 11);
        check_pulse_window(rst_edge + 1, rst_edge + 10, rst_edge + 2);

        // full write and read-back of mtimecmp
        cmp_model = rand64();
        axi_write(`CLINT_MTIMECMP_OFS, cmp_model, 8'hFF, resp, w_edge);
        check(resp == RESP_OKAY, "mtimecmp write not answered with OKAY");
        axi_read(`CLINT_MTIMECMP_OFS, 0, got, resp, r_edge);
        check(resp == RESP_OKAY, "mtimecmp read not answered with OKAY");
        check(got === cmp_model, $sformatf("mtimecmp read %h, expected %h", got, cmp_model));

        repeat (4)
        begin
            data = rand64();
            strb = 8'(lcg_next());
            axi_write(`CLINT_MTIMECMP_OFS, data, strb, resp, w_edge);
            cmp_model = apply_strobes(cmp_model, data, strb);
            axi_read(`CLINT_MTIMECMP_OFS, 0, got, resp, r_edge);
            check(got === cmp_model,
                  $sformatf("strobe %h: mtimecmp read %h, expected %h", strb, got, cmp_model));
        end

        // counting with read back-pressure
        mtime_val = rand64();
        axi_write(`CLINT_MTIME_OFS, mtime_val, 8'hFF, resp, w_edge);
        check(resp == RESP_OKAY, "mtime write not answered with OKAY");
        repeat (3)
        begin
            repeat (lcg_next() % 8) @(posedge clk);
            axi_read(`CLINT_MTIME_OFS, 1 + lcg_next() % 6, got, resp, r_edge);
            expected = mtime_val + 64'(r_edge - w_edge);
            check(got === expected, $sformatf("mtime read %h, expected %h", got, expected));
        end

        // first crossing, mtime parked low and compare armed far above it
        axi_write(`CLINT_MTIME_OFS, 64'd0, 8'hFF, resp, w_edge);
        data = rand64();
        cmp_model = {16'h0, data[47:0]} | 64'h1_0000;
        axi_write(`CLINT_MTIMECMP_OFS, cmp_model, 8'hFF, resp, c_edge);
        mtime_val = cmp_model - 64'd20;
        axi_write(`CLINT_MTIME_OFS, mtime_val, 8'hFF, resp, w_edge);
        // reached at W+20, high in the cycle from W+21, seen at the next edge
        wait_until_edge(w_edge + 41);
        check_pulse_window(w_edge + 1, w_edge + 40, w_edge + int'(cmp_model - mtime_val) + 2);

        // raise the compare past mtime and cross again
        cmp_model = cmp_model + 64'd100;
        axi_write(`CLINT_MTIMECMP_OFS, cmp_model, 8'hFF, resp, c_edge);
        wait_until_edge(w_edge + 141);
        check_pulse_window(c_edge + 1, w_edge + 140, w_edge + int'(cmp_model - mtime_val) + 2);

        // unmapped offset
        axi_write(UNMAPPED_OFS, rand64(), 8'hFF, resp, c_edge);
        check(resp == RESP_SLVERR, "unmapped write not answered with SLVERR");
        axi_read(`CLINT_MTIMECMP_OFS, 0, got, resp, r_edge);
        check(got === cmp_model, $sformatf("mtimecmp %h after unmapped write", got));
        axi_read(`CLINT_MTIME_OFS, 0, got, resp, r_edge);
        expected = mtime_val + 64'(r_edge - w_edge);
        check(got === expected, $sformatf("mtime %h after unmapped write, expected %h",
              got, expected));
        axi_read(UNMAPPED_OFS, 2, got, resp, r_edge);
        check(resp == RESP_SLVERR, "unmapped read not answered with SLVERR");
        check(got === 64'd0, $sformatf("unmapped read returned %h", got));

        repeat (5) @(posedge clk);
        if (dut_i.asserts_i.fail_cnt == 0)
        begin
            $display("TESTS PASSED");
            $finish;
        end
        else
        begin
            $display("bound protocol assertions reported failures");
            $display("TESTS FAILED");
            $fatal(1);
        end
    end

endmodule

// ==== files.f ====
+incdir+verilog
verilog/clint_pkg.sv
verilog/clint_reg_if.sv
verilog/clint_axi_slave.sv
verilog/clint_mtime.sv
verilog/clint_mtimecmp.sv
verilog/clint_top.sv
tests/clint_asserts.sv
tests/clint_tb.sv
